//--- Makefile
VERILATOR := verilator
TOP       := lsu_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# the simulator is rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run passes only if the pass message shows up in the simulator output.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Simulation PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/lsu_store_align.sv
source/lsu_load_extend.sv
source/lsu_data_ram.sv
source/lsu_top.sv
tests/lsu_tb.sv

//--- source/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic                         i_clk,
    input  logic                         i_arst_n,

    input  logic                         i_req_valid,
    input  logic                         i_req_we,
    input  logic [1 : 0]                 i_req_size,
    input  logic                         i_req_unsigned,
    input  lsu_addr_u                    i_req_addr,
    output logic                         o_req_ready,

    input  logic                         i_rsp_ready,
    output logic                         o_rsp_valid,
    output logic                         o_rsp_err,

    output logic                         o_ram_rd_en,
    output logic                         o_ram_wr_en,

    output logic [1 : 0]                 o_ld_size,
    output logic                         o_ld_unsigned,
    output logic [LSU_OFF_WIDTH - 1 : 0] o_ld_off,
    output logic                         o_rsp_is_load
);

    logic w_accept;
    logic w_misaligned;

    // ------------------------------
    // handshake and alignment
    // ------------------------------
    // a new request may enter when nothing is pending or the pending
    // response leaves in this same cycle.
    assign o_req_ready = !o_rsp_valid || i_rsp_ready;
    assign w_accept    = i_req_valid && o_req_ready;

    // the address must be a multiple of the access size.
    always_comb begin
        case (i_req_size)
            LSU_SIZE_B: w_misaligned = 1'b0;
            LSU_SIZE_H: w_misaligned = i_req_addr.raw[0];
            LSU_SIZE_W: w_misaligned = |i_req_addr.raw[1 : 0];
            default:    w_misaligned = |i_req_addr.raw[2 : 0];
        endcase
    end

    // misaligned requests never reach the ram.
    assign o_ram_rd_en = w_accept && !i_req_we && !w_misaligned;
    assign o_ram_wr_en = w_accept &&  i_req_we && !w_misaligned;

    // ------------------------------
    // response state
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp_valid   <= 1'b0;
            o_rsp_err     <= 1'b0;
            o_rsp_is_load <= 1'b0;
        end
        else if (w_accept) begin
            o_rsp_valid   <= 1'b1;
            o_rsp_err     <= w_misaligned;
            o_rsp_is_load <= !i_req_we && !w_misaligned;
        end
        else if (i_rsp_ready) begin
            o_rsp_valid   <= 1'b0;
        end
    end

    // load context for the extension logic, used one cycle after acceptance
    // together with the ram read word.
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_ld_size     <= i_req_size;
            o_ld_unsigned <= i_req_unsigned;
            o_ld_off      <= i_req_addr.fields.off;
        end
    end

endmodule

//--- source/lsu_data_ram.sv
`timescale 1ns/100ps

module lsu_data_ram import lsu_pkg::*; (
    input  logic                          i_clk,

    input  logic                          i_rd_en,
    input  logic                          i_wr_en,
    input  logic [LSU_IDX_WIDTH - 1 : 0]  i_idx,
    input  logic [LSU_DATA_WIDTH - 1 : 0] i_wdata,
    input  logic [LSU_BYTES - 1 : 0]      i_mask,

    output logic [LSU_DATA_WIDTH - 1 : 0] o_rdata
);

    logic [LSU_DATA_WIDTH - 1 : 0] r_mem [LSU_RAM_DEPTH];

    // ------------------------------
    // byte masked write
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < LSU_BYTES; b++) begin
                if (i_mask[b]) begin
                    r_mem[i_idx][b * 8 +: 8] <= i_wdata[b * 8 +: 8];
                end
            end
        end
    end

    // ------------------------------
    // registered read
    // ------------------------------
    // the read word holds between reads, which keeps a stalled response stable.
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rdata <= r_mem[i_idx];
        end
    end

endmodule

//--- source/lsu_load_extend.sv
`timescale 1ns/100ps

module lsu_load_extend import lsu_pkg::*; (
    input  logic [1 : 0]                  i_size,
    input  logic                          i_unsigned,
    input  logic [LSU_OFF_WIDTH - 1 : 0]  i_off,
    input  logic                          i_is_load,
    input  logic [LSU_DATA_WIDTH - 1 : 0] i_rdata,

    output logic [LSU_DATA_WIDTH - 1 : 0] o_rsp_rdata
);

    logic [LSU_DATA_WIDTH - 1 : 0] w_shifted;
    logic                          w_sign_b;
    logic                          w_sign_h;
    logic                          w_sign_w;
    logic [LSU_DATA_WIDTH - 1 : 0] w_extended;

    // ------------------------------
    // lane selection
    // ------------------------------
    // the addressed lane moves down to bit zero.
    assign w_shifted = i_rdata >> {i_off, 3'b000};

    // each fill bit is zero when the load is unsigned.
    assign w_sign_b = !i_unsigned && w_shifted[7];
    assign w_sign_h = !i_unsigned && w_shifted[15];
    assign w_sign_w = !i_unsigned && w_shifted[31];

    // ------------------------------
    // extension
    // ------------------------------
    always_comb begin
        case (i_size)
            LSU_SIZE_B: begin
                w_extended = {{(LSU_DATA_WIDTH - 8){w_sign_b}}, w_shifted[7 : 0]};
            end
            LSU_SIZE_H: begin
                w_extended = {{(LSU_DATA_WIDTH - 16){w_sign_h}}, w_shifted[15 : 0]};
            end
            LSU_SIZE_W: begin
                w_extended = {{(LSU_DATA_WIDTH - 32){w_sign_w}}, w_shifted[31 : 0]};
            end
            default: begin
                w_extended = w_shifted;
            end
        endcase
    end

    // stores and error responses return zero data.
    assign o_rsp_rdata = i_is_load ? w_extended : '0;

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------
    // data and address widths
    // ------------------------------
    localparam int LSU_DATA_WIDTH = 64;
    localparam int LSU_BYTES      = LSU_DATA_WIDTH / 8;
    localparam int LSU_ADDR_WIDTH = 11;
    localparam int LSU_OFF_WIDTH  = 3;
    localparam int LSU_IDX_WIDTH  = 8;
    localparam int LSU_RAM_DEPTH  = 256;

    // ------------------------------
    // access size codes
    // ------------------------------
    // the codes follow the low two bits of the load/store funct3 field.
    localparam logic [1:0] LSU_SIZE_B = 2'd0;
    localparam logic [1:0] LSU_SIZE_H = 2'd1;
    localparam logic [1:0] LSU_SIZE_W = 2'd2;
    localparam logic [1:0] LSU_SIZE_D = 2'd3;

    // ------------------------------
    // request address
    // ------------------------------
    // word index selects the ram row, offset selects the byte lane.
    typedef struct packed {
        logic [LSU_IDX_WIDTH - 1 : 0] idx;
        logic [LSU_OFF_WIDTH - 1 : 0] off;
    } lsu_addr_s;

    // the same address word is used raw for the alignment check and split
    // into index and offset for the datapath.
    typedef union packed {
        logic [LSU_ADDR_WIDTH - 1 : 0] raw;
        lsu_addr_s                     fields;
    } lsu_addr_u;

endpackage

//--- source/lsu_store_align.sv
`timescale 1ns/100ps

module lsu_store_align import lsu_pkg::*; (
    input  logic [1 : 0]                  i_size,
    input  logic [LSU_OFF_WIDTH - 1 : 0]  i_off,
    input  logic [LSU_DATA_WIDTH - 1 : 0] i_wdata,

    output logic [LSU_DATA_WIDTH - 1 : 0] o_ram_wdata,
    output logic [LSU_BYTES - 1 : 0]      o_ram_mask
);

    logic [LSU_BYTES - 1 : 0]      w_base_mask;
    logic [LSU_BYTES - 1 : 0]      w_mask;
    logic [LSU_DATA_WIDTH - 1 : 0] w_shifted;

    // ------------------------------
    // byte mask
    // ------------------------------
    // a run of ones as long as the access, starting at lane zero.
    always_comb begin
        case (i_size)
            LSU_SIZE_B: w_base_mask = {{(LSU_BYTES - 1){1'b0}}, 1'b1};
            LSU_SIZE_H: w_base_mask = {{(LSU_BYTES - 2){1'b0}}, 2'b11};
            LSU_SIZE_W: w_base_mask = {{(LSU_BYTES - 4){1'b0}}, 4'hf};
            default:    w_base_mask = {LSU_BYTES{1'b1}};
        endcase
    end

    // alignment keeps the run inside the word, so no bits fall off the top.
    assign w_mask     = w_base_mask << i_off;
    assign o_ram_mask = w_mask;

    // ------------------------------
    // lane placement
    // ------------------------------
    assign w_shifted = i_wdata << {i_off, 3'b000};

    // lanes outside the mask are cleared so that only the written bytes carry data.
    always_comb begin
        for (int b = 0; b < LSU_BYTES; b++) begin
            if (w_mask[b]) begin
                o_ram_wdata[b * 8 +: 8] = w_shifted[b * 8 +: 8];
            end
            else begin
                o_ram_wdata[b * 8 +: 8] = 8'h00;
            end
        end
    end

endmodule

//--- source/lsu_top.sv
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
    input  logic                          i_clk,
    input  logic                          i_arst_n,

    input  logic                          i_req_valid,
    input  logic                          i_req_we,
    input  logic [1 : 0]                  i_req_size,
    input  logic                          i_req_unsigned,
    input  logic [LSU_ADDR_WIDTH - 1 : 0] i_req_addr,
    input  logic [LSU_DATA_WIDTH - 1 : 0] i_req_wdata,
    output logic                          o_req_ready,

    input  logic                          i_rsp_ready,
    output logic                          o_rsp_valid,
    output logic [LSU_DATA_WIDTH - 1 : 0] o_rsp_rdata,
    output logic                          o_rsp_err
);

    lsu_addr_u                     w_addr;
    logic                          w_ram_rd_en;
    logic                          w_ram_wr_en;
    logic [LSU_DATA_WIDTH - 1 : 0] w_ram_wdata;
    logic [LSU_BYTES - 1 : 0]      w_ram_mask;
    logic [LSU_DATA_WIDTH - 1 : 0] w_ram_rdata;
    logic [1 : 0]                  w_ld_size;
    logic                          w_ld_unsigned;
    logic [LSU_OFF_WIDTH - 1 : 0]  w_ld_off;
    logic                          w_rsp_is_load;

    assign w_addr = i_req_addr;

    lsu_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_req_valid    (i_req_valid),
        .i_req_we       (i_req_we),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_addr     (w_addr),
        .o_req_ready    (o_req_ready),
        .i_rsp_ready    (i_rsp_ready),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_err      (o_rsp_err),
        .o_ram_rd_en    (w_ram_rd_en),
        .o_ram_wr_en    (w_ram_wr_en),
        .o_ld_size      (w_ld_size),
        .o_ld_unsigned  (w_ld_unsigned),
        .o_ld_off       (w_ld_off),
        .o_rsp_is_load  (w_rsp_is_load)
    );

    lsu_store_align u_store_align (
        .i_size      (i_req_size),
        .i_off       (w_addr.fields.off),
        .i_wdata     (i_req_wdata),
        .o_ram_wdata (w_ram_wdata),
        .o_ram_mask  (w_ram_mask)
    );

    // the ram row comes straight from the word index of the request address.
    lsu_data_ram u_data_ram (
        .i_clk   (i_clk),
        .i_rd_en (w_ram_rd_en),
        .i_wr_en (w_ram_wr_en),
        .i_idx   (w_addr.fields.idx),
        .i_wdata (w_ram_wdata),
        .i_mask  (w_ram_mask),
        .o_rdata (w_ram_rdata)
    );

    lsu_load_extend u_load_extend (
        .i_size      (w_ld_size),
        .i_unsigned  (w_ld_unsigned),
        .i_off       (w_ld_off),
        .i_is_load   (w_rsp_is_load),
        .i_rdata     (w_ram_rdata),
        .o_rsp_rdata (o_rsp_rdata)
    );

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb import lsu_pkg::*; ();

    localparam int    CLK_HALF  = 4;
    localparam int    MAX_TESTS = 64;
    localparam int    REC_WORDS = 7;
    localparam string TEST_FILE = "tests/lsu_tests.mem";

    logic                          i_clk;
    logic                          i_arst_n;
    logic                          i_req_valid;
    logic                          i_req_we;
    logic [1 : 0]                  i_req_size;
    logic                          i_req_unsigned;
    logic [LSU_ADDR_WIDTH - 1 : 0] i_req_addr;
    logic [LSU_DATA_WIDTH - 1 : 0] i_req_wdata;
    logic                          o_req_ready;
    logic                          i_rsp_ready;
    logic                          o_rsp_valid;
    logic [LSU_DATA_WIDTH - 1 : 0] o_rsp_rdata;
    logic                          o_rsp_err;

    // each data file row holds seven words.
    logic [63 : 0]                 test_mem [MAX_TESTS * REC_WORDS];
    logic                          t_we [MAX_TESTS];
    logic [1 : 0]                  t_size [MAX_TESTS];
    logic                          t_unsigned [MAX_TESTS];
    logic [LSU_ADDR_WIDTH - 1 : 0] t_addr [MAX_TESTS];
    logic [LSU_DATA_WIDTH - 1 : 0] t_wdata [MAX_TESTS];
    logic [LSU_DATA_WIDTH - 1 : 0] t_rdata [MAX_TESTS];
    logic                          t_err [MAX_TESTS];

    int num_tests;
    int cycle;
    int error_count;
    int pass_count;
    int fail_count;
    bit tests_loaded;
    int idx_q [$];
    int accept_q [$];

    lsu_top UUT (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_req_valid    (i_req_valid),
        .i_req_we       (i_req_we),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .o_req_ready    (o_req_ready),
        .i_rsp_ready    (i_rsp_ready),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_rdata    (o_rsp_rdata),
        .o_rsp_err      (o_rsp_err)
    );

    initial i_clk = 1'b0;
    always #CLK_HALF i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [63 : 0] actual,
                               input logic [63 : 0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic load_tests();
        int base;
        // unused entries get a pattern whose first column is never 0 or 1.
        for (int i = 0; i < MAX_TESTS * REC_WORDS; i++) begin
            test_mem[i] = {~32'(i), 32'(i)};
        end
        $readmemh(TEST_FILE, test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_mem[num_tests * REC_WORDS] <= 64'd1) begin
            base                  = num_tests * REC_WORDS;
            t_we[num_tests]       = test_mem[base][0];
            t_size[num_tests]     = test_mem[base + 1][1 : 0];
            t_unsigned[num_tests] = test_mem[base + 2][0];
            t_addr[num_tests]     = test_mem[base + 3][LSU_ADDR_WIDTH - 1 : 0];
            t_wdata[num_tests]    = test_mem[base + 4];
            t_rdata[num_tests]    = test_mem[base + 5];
            t_err[num_tests]      = test_mem[base + 6][0];
            num_tests++;
        end
    endtask

    // each request is held until the DUT takes it, then the next follows at once.
    task automatic drive_requests();
        for (int i = 0; i < num_tests; i++) begin
            @(posedge i_clk);
            #1;
            i_req_valid    = 1'b1;
            i_req_we       = t_we[i];
            i_req_size     = t_size[i];
            i_req_unsigned = t_unsigned[i];
            i_req_addr     = t_addr[i];
            i_req_wdata    = t_wdata[i];
            do begin
                @(negedge i_clk);
            end while (!o_req_ready);
            idx_q.push_back(i);
            accept_q.push_back(cycle + 1);
        end
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
    endtask

    // i_rsp_ready stays low for 0 to 3 cycles of every response.
    task automatic collect_responses();
        int stall;
        int idx;
        int exp_cycle;
        int errors_before;
        for (int n = 0; n < num_tests; n++) begin
            stall       = $urandom_range(3, 0);
            i_rsp_ready = (stall == 0);
            do begin
                @(negedge i_clk);
            end while (!o_rsp_valid);
            if (idx_q.size() == 0) begin
                $display("a response showed up at %0t with no accepted request", $time);
                error_count++;
                return;
            end
            idx           = idx_q.pop_front();
            exp_cycle     = accept_q.pop_front();
            errors_before = error_count;
            check_value("response latency", 64'(cycle), 64'(exp_cycle));
            while (1'b1) begin
                check_value("o_rsp_valid", 64'(o_rsp_valid), 64'd1);
                check_value("o_rsp_rdata", o_rsp_rdata, t_rdata[idx]);
                check_value("o_rsp_err", 64'(o_rsp_err), 64'(t_err[idx]));
                check_value("o_req_ready", 64'(o_req_ready), 64'(i_rsp_ready));
                if (i_rsp_ready) begin
                    break;
                end
                @(posedge i_clk);
                #1;
                stall--;
                i_rsp_ready = (stall == 0);
                @(negedge i_clk);
            end
            @(posedge i_clk);
            #1;
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %0d %s size %0d addr %h passed", idx,
                         t_we[idx] ? "store" : "load", t_size[idx], t_addr[idx]);
            end
            else begin
                fail_count++;
                $display("test %0d %s size %0d addr %h failed", idx,
                         t_we[idx] ? "store" : "load", t_size[idx], t_addr[idx]);
            end
        end
        i_rsp_ready = 1'b0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int errors_before;
        void'($urandom(32'hfd46532b));
        i_arst_n       = 1'b0;
        i_req_valid    = 1'b0;
        i_req_we       = 1'b0;
        i_req_size     = LSU_SIZE_B;
        i_req_unsigned = 1'b0;
        i_req_addr     = '0;
        i_req_wdata    = '0;
        i_rsp_ready    = 1'b0;
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        load_tests();
        tests_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("no tests could be read from %s", TEST_FILE);
            error_count++;
        end

        repeat (2) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;

        @(negedge i_clk);
        errors_before = error_count;
        check_value("o_rsp_valid", 64'(o_rsp_valid), 64'd0);
        check_value("o_rsp_err", 64'(o_rsp_err), 64'd0);
        check_value("o_req_ready", 64'(o_req_ready), 64'd1);
        if (error_count == errors_before) begin
            pass_count++;
            $display("reset state check passed");
        end
        else begin
            fail_count++;
            $display("reset state check failed");
        end

        @(posedge i_clk);
        #1;
        fork
            drive_requests();
            collect_responses();
        join

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // the limit allows 8 cycles per test plus some room for reset.
    initial begin
        wait (tests_loaded);
        repeat (num_tests * 8 + 20) @(posedge i_clk);
        $display("the run timed out after %0d cycles", num_tests * 8 + 20);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tests/lsu_tests.mem
// columns: we size unsigned addr wdata expected_rdata expected_err
// size 0 byte, 1 half, 2 word, 3 double; we 1 is a store and 0 a load.
// double word round trip
1 3 0 000 0123456789abcdef 0000000000000000 0
0 3 0 000 0000000000000000 0123456789abcdef 0
1 3 0 7f8 fedcba9876543210 0000000000000000 0
0 3 0 7f8 0000000000000000 fedcba9876543210 0
// partial stores merge into word 2
1 3 0 010 1111111111111111 0000000000000000 0
1 0 0 013 ffffffffffffffaa 0000000000000000 0
1 1 0 016 123456789abcbeef 0000000000000000 0
0 3 0 010 0000000000000000 beef1111aa111111 0
1 2 0 014 9999999913572468 0000000000000000 0
1 0 0 011 000000000000005a 0000000000000000 0
0 3 0 010 0000000000000000 13572468aa115a11 0
// sign and zero extension from word 3
1 3 0 018 8123f00d7e5a9c80 0000000000000000 0
0 0 0 018 0000000000000000 ffffffffffffff80 0
0 0 1 018 0000000000000000 0000000000000080 0
0 0 0 01b 0000000000000000 000000000000007e 0
0 1 0 01a 0000000000000000 0000000000007e5a 0
0 1 0 018 0000000000000000 ffffffffffff9c80 0
0 1 1 018 0000000000000000 0000000000009c80 0
0 2 0 01c 0000000000000000 ffffffff8123f00d 0
0 2 1 01c 0000000000000000 000000008123f00d 0
0 2 0 018 0000000000000000 000000007e5a9c80 0
0 0 0 01e 0000000000000000 0000000000000023 0
0 1 0 01e 0000000000000000 ffffffffffff8123 0
0 0 0 01d 0000000000000000 fffffffffffffff0 0
// misaligned requests
1 1 0 011 ffffffffffffffff 0000000000000000 1
1 2 0 012 ffffffffffffffff 0000000000000000 1
1 3 0 014 ffffffffffffffff 0000000000000000 1
0 1 0 019 0000000000000000 0000000000000000 1
0 2 1 01a 0000000000000000 0000000000000000 1
0 3 0 01c 0000000000000000 0000000000000000 1
// memory unchanged by the misaligned stores
0 3 0 010 0000000000000000 13572468aa115a11 0
0 3 0 018 0000000000000000 8123f00d7e5a9c80 0
0 3 0 000 0000000000000000 0123456789abcdef 0
